/* build.f */
rtl/xv_pkg.sv
rtl/video_timing_if.sv
rtl/video_timing.sv
rtl/vgen_regs.sv
rtl/pixel_fetch.sv
rtl/video_gen_top.sv
dv/video_gen_props.sv
dv/video_gen_tb.sv

/* dv/video_gen_props.sv */
/*
 * Concurrent assertions on the video generator outputs, bound into video_gen_top.
 * Covers blanking during sync, single-cycle interrupts and fetch while disabled.
 */
`timescale 1ns/10ps
`default_nettype none

module video_gen_props (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic hsync_i,
    input wire logic vsync_i,
    input wire logic dv_de_i,
    input wire logic vsync_intr_i,
    input wire logic vline_intr_i,
    input wire logic vram_sel_i,
    input wire logic plane_disable_i
);
    import xv_pkg::*;

    de_outside_sync: assert property (@(posedge clk) disable iff (reset_i)
        dv_de_i |-> (hsync_i != H_SYNC_POLARITY) && (vsync_i != V_SYNC_POLARITY))
        else $error("display enable high while a sync is active");

    vsync_intr_single: assert property (@(posedge clk) disable iff (reset_i)
        vsync_intr_i |=> !vsync_intr_i)
        else $error("vsync interrupt longer than one cycle");

    vline_intr_single: assert property (@(posedge clk) disable iff (reset_i)
        vline_intr_i |=> !vline_intr_i)
        else $error("line interrupt longer than one cycle");

    // a read is requested one cycle before it shows, so both cycles must be enabled
    no_fetch_disabled: assert property (@(posedge clk) disable iff (reset_i)
        vram_sel_i |-> !plane_disable_i && !$past(plane_disable_i))
        else $error("vram read issued with the plane disabled");

endmodule

bind video_gen_top video_gen_props u_props (
    .clk             (clk),
    .reset_i         (reset_i),
    .hsync_i         (hsync_o),
    .vsync_i         (vsync_o),
    .dv_de_i         (dv_de_o),
    .vsync_intr_i    (vsync_intr_o),
    .vline_intr_i    (vline_intr_o),
    .vram_sel_i      (vram_sel_o),
    .plane_disable_i (regs_cfg.plane_disable)
);

`default_nettype wire

/* dv/video_gen_tb.sv */
/*
 * Testbench for the video generator with a small test timing.
 * Applies a table of plane configurations and checks sync counts, pixels,
 * interrupts and register read-back over one full frame per row.
 */
`timescale 1ns/10ps
`default_nettype none

module video_gen_tb;
    import xv_pkg::*;

    localparam int H_VISIBLE    = 16;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 3;
    localparam int H_BACK       = 5;
    localparam int V_VISIBLE    = 4;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;
    localparam int ROWS         = 4;
    localparam int WATCHDOG_NS  = ((ROWS * 3 + 4) * FRAME_CYCLES + ROWS * 64) * 20;

    typedef struct packed {
        vram_addr_t start_addr;
        vram_addr_t line_width;
        pal_index_t colorbase;
        logic       plane_disable;
        logic       line_intr_ena;
        count_t     line_intr;
        logic [1:0] exp_vline;                      // line interrupts expected per frame
    } row_t;

    logic       clk;
    logic       reset_i;
    logic       enable_i;
    logic       vgen_reg_wr_i;
    reg_num_t   vgen_reg_num_i;
    vram_word_t vgen_reg_data_i;
    vram_word_t vgen_reg_data_o;
    logic       vram_sel_o;
    vram_addr_t vram_addr_o;
    vram_word_t vram_data_i;
    pal_index_t pal_index_o;
    logic       hsync_o;
    logic       vsync_o;
    logic       dv_de_o;
    logic       vsync_intr_o;
    logic       vline_intr_o;
    vram_word_t vram [256];
    integer     seed;
    row_t       rows [ROWS];

    video_gen_top #(
        .H_VISIBLE (H_VISIBLE), .H_FRONT (H_FRONT), .H_SYNC (H_SYNC), .H_BACK (H_BACK),
        .V_VISIBLE (V_VISIBLE), .V_FRONT (V_FRONT), .V_SYNC (V_SYNC), .V_BACK (V_BACK)
    ) UUT (.*);

    always #10 clk = ~clk;

    // one cycle read latency
    always @(posedge clk) begin
        if (vram_sel_o) begin
            vram_data_i <= vram[vram_addr_o[7:0]];
        end
    end

    initial begin
        #(WATCHDOG_NS);
        abort_run("Timeout: the DUT did not finish the frames in time");
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Some tests failed");
        $fatal(1, "run stopped");
    endtask

    task automatic pixel_equal(input string name, input pal_index_t exp, input pal_index_t act);
        if (act !== exp) begin
            $display("Fail: time %0t, %s expected %h, got %h", $time, name, exp, act);
            abort_run("palette index mismatch");
        end
    endtask

    task automatic word_equal(input string name, input vram_word_t exp, input vram_word_t act);
        if (act !== exp) begin
            $display("Fail: time %0t, %s expected %h, got %h", $time, name, exp, act);
            abort_run("register read-back mismatch");
        end
    endtask

    task automatic bit_equal(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            $display("Fail: time %0t, %s expected %b, got %b", $time, name, exp, act);
            abort_run("output bit mismatch");
        end
    endtask

    task automatic count_equal(input string name, input int exp, input int act);
        if (act != exp) begin
            $display("Fail: time %0t, %s expected %0d, got %0d", $time, name, exp, act);
            abort_run("per-frame count mismatch");
        end
    endtask

    task automatic write_reg(input reg_num_t num, input vram_word_t data);
        @(posedge clk);
        vgen_reg_wr_i   <= 1'b1;
        vgen_reg_num_i  <= num;
        vgen_reg_data_i <= data;
        @(posedge clk);
        vgen_reg_wr_i   <= 1'b0;
    endtask

    task automatic readback(input reg_num_t num, input vram_word_t exp, input string name);
        @(posedge clk);
        vgen_reg_num_i <= num;
        @(posedge clk);                             // data registered here
        @(negedge clk);
        word_equal(name, exp, vgen_reg_data_o);
    endtask

    task automatic wait_frame_irq();
        do begin
            @(negedge clk);
        end while (vsync_intr_o !== 1'b1);
    endtask

    // one frame period starting right after a vsync interrupt
    task automatic scan_frame(input row_t r);
        int         hs;
        int         vs;
        int         de;
        int         vsi;
        int         vli;
        int         x;
        int         y;
        vram_addr_t addr;
        vram_word_t word;
        pal_index_t exp_pix;
        hs = 0;
        vs = 0;
        de = 0;
        vsi = 0;
        vli = 0;
        x = 0;
        y = 0;
        for (int i = 0; i < FRAME_CYCLES; i++) begin
            @(negedge clk);
            hs += (hsync_o == H_SYNC_POLARITY);
            vs += (vsync_o == V_SYNC_POLARITY);
            vsi += vsync_intr_o;
            vli += vline_intr_o;
            if (dv_de_o) begin
                de++;
                addr = r.start_addr + vram_addr_t'(y) * r.line_width + vram_addr_t'(x / 4);
                word = vram[addr[7:0]];
                exp_pix = r.plane_disable ? 8'h00 :
                          {r.colorbase[7:4], word[4 * (3 - x % 4) +: 4]};
                pixel_equal($sformatf("pal_index_o x%0d y%0d", x, y), exp_pix, pal_index_o);
                x++;
                if (x == H_VISIBLE) begin
                    x = 0;
                    y++;
                end
            end else if (x != 0) begin
                abort_run("display enable dropped in the middle of a visible line");
            end
        end
        count_equal("hsync_o active cycles", H_SYNC * V_TOTAL, hs);
        count_equal("vsync_o active cycles", V_SYNC * H_TOTAL, vs);
        count_equal("dv_de_o high cycles", V_VISIBLE * H_VISIBLE, de);
        count_equal("visible lines", V_VISIBLE, y);
        count_equal("vsync_intr_o pulses", 1, vsi);
        count_equal("vline_intr_o pulses", int'(r.exp_vline), vli);
    endtask

    initial begin
        vram_word_t gfx_word;
        vram_word_t lint_word;
        seed = 28;
        for (int i = 0; i < 256; i++) begin
            vram[i] = vram_word_t'($random(seed));
        end
        // start, width, colorbase, disable, line intr enable, line, expected pulses
        rows[0] = {16'h0000, 16'd4, 8'h5A, 1'b0, 1'b1, 11'd2, 2'd1};
        rows[1] = {16'h0030, 16'd6, 8'hA3, 1'b0, 1'b0, 11'd0, 2'd0};
        rows[2] = {16'h0040, 16'd4, 8'h3C, 1'b1, 1'b1, 11'd5, 2'd1};
        rows[3] = {16'h00F0, 16'd5, 8'hC7, 1'b0, 1'b1, 11'd9, 2'd0};  // past the last line

        clk             = 1'b0;
        reset_i         = 1'b1;
        enable_i        = 1'b0;
        vgen_reg_wr_i   = 1'b0;
        vgen_reg_num_i  = '0;
        vgen_reg_data_i = '0;
        vram_data_i     = '0;

        repeat (4) @(posedge clk);
        @(negedge clk);
        bit_equal("hsync_o", 1'b0, hsync_o);        // all outputs low in reset
        bit_equal("vsync_o", 1'b0, vsync_o);
        bit_equal("dv_de_o", 1'b0, dv_de_o);
        bit_equal("vsync_intr_o", 1'b0, vsync_intr_o);
        bit_equal("vline_intr_o", 1'b0, vline_intr_o);
        bit_equal("vram_sel_o", 1'b0, vram_sel_o);
        word_equal("vgen_reg_data_o", 16'h0000, vgen_reg_data_o);
        pixel_equal("pal_index_o", 8'h00, pal_index_o);
        @(posedge clk);
        reset_i <= 1'b0;

        // no display until enable is seen at a frame end
        repeat (2 * FRAME_CYCLES) begin
            @(negedge clk);
            bit_equal("dv_de_o", 1'b0, dv_de_o);
        end
        @(posedge clk);
        enable_i <= 1'b1;

        for (int r = 0; r < ROWS; r++) begin
            gfx_word  = {rows[r].colorbase, rows[r].plane_disable, 7'b0};
            lint_word = {rows[r].line_intr_ena, 4'b0, rows[r].line_intr};
            write_reg(DISPSTART, rows[r].start_addr);
            write_reg(DISPWIDTH, rows[r].line_width);
            write_reg(GFXCTRL, gfx_word);
            write_reg(LINEINTR, lint_word);
            readback(DISPSTART, rows[r].start_addr, "DISPSTART read-back");
            readback(DISPWIDTH, rows[r].line_width, "DISPWIDTH read-back");
            readback(GFXCTRL, gfx_word, "GFXCTRL read-back");
            readback(LINEINTR, lint_word, "LINEINTR read-back");
            readback(R_WIDTH, 16'(H_VISIBLE), "R_WIDTH read-back");
            readback(R_HEIGHT, 16'(V_VISIBLE), "R_HEIGHT read-back");
            readback(4'd5, 16'h0000, "unused register read-back");
            wait_frame_irq();                       // start address takes a frame end
            wait_frame_irq();
            scan_frame(rows[r]);
        end

        $display("All tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/pixel_fetch.sv */
/*
 * Single 4-bpp bitmap plane.
 * Reads one VRAM word per 4 pixels ahead of the beam and shifts out palette
 * indexes aligned with the registered display enable.
 */
`timescale 1ns/10ps
`default_nettype none

module pixel_fetch #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire xv_pkg::vgen_regs_t regs_cfg,
    video_timing_if.fetch           tmg,
    output logic                    vram_sel_o,
    output xv_pkg::vram_addr_t      vram_addr_o,
    input  wire xv_pkg::vram_word_t vram_data_i,     // valid one cycle after select
    output xv_pkg::pal_index_t      pal_index_o
);
    import xv_pkg::*;

    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam count_t     FETCH_BEGIN = count_t'(H_OFF - 8);    // two words ahead
    localparam count_t     FETCH_END   = count_t'(H_TOTAL - 8);
    localparam logic [1:0] PHASE_OFS   = 2'(H_OFF % 4);

    vram_addr_t line_addr;                          // first word of current line
    vram_addr_t word_addr;                          // next word to read
    vram_word_t next_word;                          // word waiting for the shifter
    vram_word_t shift_word;                         // 4 pixels, leftmost on top
    logic [1:0] phase;                              // 0 on each 4-pixel boundary
    logic       in_window;
    logic       rd_go;
    logic       rd_sel;
    logic       rd_pending;

    assign phase     = tmg.h_count[1:0] - PHASE_OFS;
    assign in_window = tmg.v_visible && (tmg.h_count >= FETCH_BEGIN) &&
                       (tmg.h_count < FETCH_END);
    assign rd_go     = in_window && (phase == 2'd2) && !regs_cfg.plane_disable;

    // data lands at phase 0 of the next group, shifter loads at its phase 3
    assign vram_sel_o = rd_sel && !regs_cfg.plane_disable;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            line_addr   <= '0;
            word_addr   <= '0;
            rd_sel      <= 1'b0;
            rd_pending  <= 1'b0;
            vram_addr_o <= '0;
            pal_index_o <= '0;
        end else begin
            rd_sel     <= rd_go;
            rd_pending <= vram_sel_o;

            if (rd_go) begin
                vram_addr_o <= word_addr;
                word_addr   <= word_addr + 1'b1;
            end

            if (tmg.frame_end) begin
                line_addr <= regs_cfg.start_addr;   // new start only per frame
                word_addr <= regs_cfg.start_addr;
            end else if (tmg.line_end && tmg.v_visible) begin
                line_addr <= line_addr + regs_cfg.line_width;
                word_addr <= line_addr + regs_cfg.line_width;
            end

            if (tmg.h_visible && tmg.v_visible && !regs_cfg.plane_disable) begin
                pal_index_o <= {regs_cfg.colorbase[7:4], shift_word[15:12]};
            end else begin
                pal_index_o <= '0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rd_pending) begin
            next_word <= vram_data_i;
        end

        if (phase == 2'd3) begin
            shift_word <= next_word;                // next 4 pixels
        end else begin
            shift_word <= {shift_word[11:0], 4'h0};
        end
    end

endmodule

`default_nettype wire

/* rtl/vgen_regs.sv */
/*
 * Configuration registers of the video generator.
 * Strobed writes update the live config, read data is registered one cycle
 * after the register number is presented.
 */
`timescale 1ns/10ps
`default_nettype none

module vgen_regs #(
    parameter int H_VISIBLE = 640,
    parameter int V_VISIBLE = 480
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               vgen_reg_wr_i,      // write strobe
    input  wire xv_pkg::reg_num_t   vgen_reg_num_i,
    input  wire xv_pkg::vram_word_t vgen_reg_data_i,
    output xv_pkg::vram_word_t      vgen_reg_data_o,
    output xv_pkg::vgen_regs_t      regs_cfg,
    video_timing_if.regs            tmg
);
    import xv_pkg::*;

    localparam vram_word_t RD_WIDTH   = vram_word_t'(H_VISIBLE);
    localparam vram_word_t RD_HEIGHT  = vram_word_t'(V_VISIBLE);
    localparam vram_addr_t LINE_WORDS = vram_addr_t'(H_VISIBLE / 4);  // 4 pixels per word

    always_ff @(posedge clk) begin
        if (reset_i) begin
            regs_cfg.start_addr    <= '0;
            regs_cfg.line_width    <= LINE_WORDS;
            regs_cfg.colorbase     <= '0;
            regs_cfg.plane_disable <= 1'b0;        // plane starts enabled
            regs_cfg.line_intr_ena <= 1'b0;
            regs_cfg.line_intr     <= '0;
        end else if (vgen_reg_wr_i) begin
            case (vgen_reg_num_i)
                DISPSTART: regs_cfg.start_addr <= vgen_reg_data_i;
                DISPWIDTH: regs_cfg.line_width <= vgen_reg_data_i;
                GFXCTRL: begin
                    regs_cfg.colorbase     <= vgen_reg_data_i[15:8];
                    regs_cfg.plane_disable <= vgen_reg_data_i[7];
                end
                LINEINTR: begin
                    regs_cfg.line_intr_ena <= vgen_reg_data_i[15];
                    regs_cfg.line_intr     <= vgen_reg_data_i[10:0];
                end
                default: begin                      // read-only or unused
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            vgen_reg_data_o <= '0;
        end else begin
            case (vgen_reg_num_i)
                DISPSTART:  vgen_reg_data_o <= regs_cfg.start_addr;
                DISPWIDTH:  vgen_reg_data_o <= regs_cfg.line_width;
                GFXCTRL:    vgen_reg_data_o <= {regs_cfg.colorbase, regs_cfg.plane_disable, 7'b0};
                LINEINTR:   vgen_reg_data_o <= {regs_cfg.line_intr_ena, 4'b0, regs_cfg.line_intr};
                R_WIDTH:    vgen_reg_data_o <= RD_WIDTH;
                R_HEIGHT:   vgen_reg_data_o <= RD_HEIGHT;
                // top bits set while in blanking
                R_SCANLINE: vgen_reg_data_o <= {~tmg.v_visible, ~tmg.h_visible, 3'b0, tmg.v_count};
                default:    vgen_reg_data_o <= '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* rtl/video_gen_top.sv */
/*
 * Top level of the video generator with a single 4-bpp bitmap plane.
 * Connects timing, config registers and pixel fetch; timing defaults to 640x480.
 */
`timescale 1ns/10ps
`default_nettype none

module video_gen_top #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               enable_i,
    input  wire logic               vgen_reg_wr_i,
    input  wire xv_pkg::reg_num_t   vgen_reg_num_i,
    input  wire xv_pkg::vram_word_t vgen_reg_data_i,
    output xv_pkg::vram_word_t      vgen_reg_data_o,
    output logic                    vram_sel_o,
    output xv_pkg::vram_addr_t      vram_addr_o,
    input  wire xv_pkg::vram_word_t vram_data_i,
    output xv_pkg::pal_index_t      pal_index_o,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    output logic                    vsync_intr_o,
    output logic                    vline_intr_o
);

    xv_pkg::vgen_regs_t regs_cfg;                   // live configuration

    video_timing_if tmg ();

    video_timing #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK),
        .V_VISIBLE (V_VISIBLE),
        .V_FRONT   (V_FRONT),
        .V_SYNC    (V_SYNC),
        .V_BACK    (V_BACK)
    ) u_timing (
        .clk          (clk),
        .reset_i      (reset_i),
        .enable_i     (enable_i),
        .regs_cfg     (regs_cfg),
        .tmg          (tmg.source),
        .hsync_o      (hsync_o),
        .vsync_o      (vsync_o),
        .dv_de_o      (dv_de_o),
        .vsync_intr_o (vsync_intr_o),
        .vline_intr_o (vline_intr_o)
    );

    vgen_regs #(
        .H_VISIBLE (H_VISIBLE),
        .V_VISIBLE (V_VISIBLE)
    ) u_regs (
        .clk             (clk),
        .reset_i         (reset_i),
        .vgen_reg_wr_i   (vgen_reg_wr_i),
        .vgen_reg_num_i  (vgen_reg_num_i),
        .vgen_reg_data_i (vgen_reg_data_i),
        .vgen_reg_data_o (vgen_reg_data_o),
        .regs_cfg        (regs_cfg),
        .tmg             (tmg.regs)
    );

    pixel_fetch #(
        .H_VISIBLE (H_VISIBLE),
        .H_FRONT   (H_FRONT),
        .H_SYNC    (H_SYNC),
        .H_BACK    (H_BACK)
    ) u_fetch (
        .clk         (clk),
        .reset_i     (reset_i),
        .regs_cfg    (regs_cfg),
        .tmg         (tmg.fetch),
        .vram_sel_o  (vram_sel_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_i (vram_data_i),
        .pal_index_o (pal_index_o)
    );

endmodule

`default_nettype wire

/* rtl/video_timing.sv */
/*
 * Horizontal and vertical sync state machines for the video generator.
 * Drives the beam position interface, registered syncs and display enable,
 * and the vsync and scan line interrupt pulses.
 */
`timescale 1ns/10ps
`default_nettype none

module video_timing #(
    parameter int H_VISIBLE = 640,
    parameter int H_FRONT   = 16,
    parameter int H_SYNC    = 96,
    parameter int H_BACK    = 48,
    parameter int V_VISIBLE = 480,
    parameter int V_FRONT   = 10,
    parameter int V_SYNC    = 2,
    parameter int V_BACK    = 33
) (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               enable_i,        // sampled at frame end
    input  wire xv_pkg::vgen_regs_t regs_cfg,
    video_timing_if.source          tmg,
    output logic                    hsync_o,
    output logic                    vsync_o,
    output logic                    dv_de_o,
    output logic                    vsync_intr_o,
    output logic                    vline_intr_o
);
    import xv_pkg::*;

    localparam int H_OFF   = H_FRONT + H_SYNC + H_BACK;   // counts before visible pixels
    localparam int H_TOTAL = H_OFF + H_VISIBLE;
    localparam int V_TOTAL = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;

    video_state_e h_state;
    video_state_e v_state;
    count_t       h_count;
    count_t       v_count;
    count_t       h_cmp;                            // last count of current h phase
    count_t       v_cmp;                            // last line of current v phase
    logic         line_end;
    logic         frame_end;
    logic         last_visible;                     // last pixel of last visible line
    logic         vg_enable;                        // frame-latched video enable

    // line starts with front porch, visible pixels are at the right end
    always_comb begin
        case (h_state)
            PRE_SYNC:  h_cmp = count_t'(H_FRONT - 1);
            SYNC:      h_cmp = count_t'(H_FRONT + H_SYNC - 1);
            POST_SYNC: h_cmp = count_t'(H_OFF - 1);
            default:   h_cmp = count_t'(H_TOTAL - 1);
        endcase
    end

    // frame starts with visible lines, blanking at the bottom
    always_comb begin
        case (v_state)
            VISIBLE:   v_cmp = count_t'(V_VISIBLE - 1);
            PRE_SYNC:  v_cmp = count_t'(V_VISIBLE + V_FRONT - 1);
            SYNC:      v_cmp = count_t'(V_VISIBLE + V_FRONT + V_SYNC - 1);
            default:   v_cmp = count_t'(V_TOTAL - 1);
        endcase
    end

    assign line_end     = (h_state == VISIBLE) && (h_count == h_cmp);
    assign frame_end    = line_end && (v_state == POST_SYNC) && (v_count == v_cmp);
    assign last_visible = line_end && (v_state == VISIBLE) && (v_count == v_cmp);

    assign tmg.h_count   = h_count;
    assign tmg.v_count   = v_count;
    assign tmg.h_visible = (h_state == VISIBLE);
    assign tmg.v_visible = (v_state == VISIBLE);
    assign tmg.line_end  = line_end;
    assign tmg.frame_end = frame_end;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            h_state      <= PRE_SYNC;
            v_state      <= VISIBLE;                // line 0 is a visible line
            h_count      <= '0;
            v_count      <= '0;
            vg_enable    <= 1'b0;                   // blank until first frame end
            hsync_o      <= 1'b0;
            vsync_o      <= 1'b0;
            dv_de_o      <= 1'b0;
            vsync_intr_o <= 1'b0;
            vline_intr_o <= 1'b0;
        end else begin
            h_count <= line_end ? '0 : h_count + 1'b1;
            if (h_count == h_cmp) begin
                h_state <= video_state_e'(h_state + 2'd1);
            end

            if (line_end) begin
                v_count <= frame_end ? '0 : v_count + 1'b1;
                if (v_count == v_cmp) begin
                    v_state <= video_state_e'(v_state + 2'd1);
                end
            end

            if (frame_end) begin
                vg_enable <= enable_i;
            end

            hsync_o <= (h_state == SYNC) ? H_SYNC_POLARITY : ~H_SYNC_POLARITY;
            vsync_o <= (v_state == SYNC) ? V_SYNC_POLARITY : ~V_SYNC_POLARITY;
            dv_de_o <= vg_enable && (h_state == VISIBLE) && (v_state == VISIBLE);

            vsync_intr_o <= last_visible;
            // first count of the selected line
            vline_intr_o <= regs_cfg.line_intr_ena && (h_count == '0) &&
                            (v_count == regs_cfg.line_intr);
        end
    end

endmodule

`default_nettype wire

/* rtl/video_timing_if.sv */
/*
 * Beam position and line/frame events from the timing generator.
 * The register block and the pixel fetch each see their own subset.
 */
`timescale 1ns/10ps
`default_nettype none

interface video_timing_if;
    import xv_pkg::*;

    count_t h_count;                                // horizontal beam count
    count_t v_count;                                // current line
    logic   h_visible;
    logic   v_visible;
    logic   line_end;                               // last count of each line
    logic   frame_end;                              // last count of the frame

    modport source (output h_count, v_count, h_visible, v_visible, line_end, frame_end);
    modport regs   (input v_count, h_visible, v_visible);
    modport fetch  (input h_count, h_visible, v_visible, line_end, frame_end);

endinterface

`default_nettype wire

/* rtl/xv_pkg.sv */
/*
 * Shared widths, types, register numbers and sync polarities for the video generator.
 * RTL blocks and the testbench import what they need from here.
 */
`default_nettype none

package xv_pkg;

    localparam int VRAM_ADDR_W = 16;                // vram word address width
    localparam int VRAM_DATA_W = 16;                // vram data word width
    localparam int COUNT_W     = 11;                // beam counter width

    typedef logic [VRAM_ADDR_W-1:0] vram_addr_t;
    typedef logic [VRAM_DATA_W-1:0] vram_word_t;
    typedef logic [COUNT_W-1:0]     count_t;
    typedef logic [7:0]             pal_index_t;
    typedef logic [3:0]             reg_num_t;

    // config register numbers, gaps are unused and read as 0
    typedef enum logic [3:0] {
        DISPSTART  = 4'd0,
        DISPWIDTH  = 4'd1,
        GFXCTRL    = 4'd2,
        LINEINTR   = 4'd3,
        R_WIDTH    = 4'd8,
        R_HEIGHT   = 4'd9,
        R_SCANLINE = 4'd11
    } aux_reg_e;

    // phase order matters, each machine steps by +1 and wraps
    typedef enum logic [1:0] {
        PRE_SYNC  = 2'd0,
        SYNC      = 2'd1,
        POST_SYNC = 2'd2,
        VISIBLE   = 2'd3
    } video_state_e;

    typedef struct packed {
        vram_addr_t start_addr;                     // first word of the frame
        vram_addr_t line_width;                     // words per line
        pal_index_t colorbase;                      // upper nibble used for 4-bpp
        logic       plane_disable;                  // no fetch, index 0
        logic       line_intr_ena;
        count_t     line_intr;                      // scan line for vline interrupt
    } vgen_regs_t;

    localparam logic H_SYNC_POLARITY = 1'b0;        // 640x480 uses negative syncs
    localparam logic V_SYNC_POLARITY = 1'b0;

endpackage

`default_nettype wire
